/* dv/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* dv/mem_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_properties (
  input logic                    clk,
  input logic                    rst,
  input logic                    ready,
  input mem_pkg::srow_t          init_row,
  input logic [`MEM_NUMRDPT-1:0] rd_vld_pipe
);

  import mem_pkg::*;

  int unsigned fail_count = 0;

  // ready is sticky once the sweep is over.
  ready_stays_high: assert property (@(posedge clk) disable iff (rst) ready |=> ready)
    else begin
      $error("ready fell after it had risen");
      fail_count++;
    end

  // nothing can be in flight before ready.
  no_valid_before_ready: assert property (@(posedge clk) disable iff (rst)
    !ready |-> (rd_vld_pipe == '0))
    else begin
      $error("read valid raised while ready is low");
      fail_count++;
    end

  // ready follows the last swept row.
  sweep_ends_at_last_row: assert property (@(posedge clk) disable iff (rst)
    $rose(ready) |-> ($past(init_row) == srow_t'(`MEM_NUMSROW - 1)))
    else begin
      $error("ready rose before the sweep reached the last row");
      fail_count++;
    end

endmodule

bind mem_ctrl mem_properties mem_properties_i (
  .clk         (clk),
  .rst         (rst),
  .ready       (ready),
  .init_row    (init_row),
  .rd_vld_pipe (rd_vld_pipe)
);

`default_nettype wire

/* dv/mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_tb;

  import mem_pkg::*;

  localparam int NMEM        = `MEM_NUMRDPT * `MEM_NUMVBNK;
  localparam int TEST_CYCLES = 250 + 404 + 37 + 18 + 60;

  logic  clk;
  logic  rst;
  logic  wr;
  addr_t wr_addr;
  data_t wr_din;
  logic  rd0;
  logic  rd1;
  addr_t rd0_addr;
  addr_t rd1_addr;
  logic  rd0_vld;
  logic  rd1_vld;
  data_t rd0_dout;
  data_t rd1_dout;
  padr_t rd0_padr;
  padr_t rd1_padr;
  logic  ready;

  logic [NMEM-1:0]              mem_write;
  logic [NMEM*`MEM_BITSROW-1:0] mem_wr_adr;
  logic [NMEM*`MEM_PHYWDTH-1:0] mem_bw;
  logic [NMEM*`MEM_PHYWDTH-1:0] mem_din;
  logic [NMEM-1:0]              mem_read;
  logic [NMEM*`MEM_BITSROW-1:0] mem_rd_adr;
  logic [NMEM*`MEM_PHYWDTH-1:0] mem_rd_dout;

  // expected response: {cycle, padr, data}.
  logic [56:0] exp_q0 [$];
  logic [56:0] exp_q1 [$];
  data_t       ref_mem [`MEM_NUMADDR];
  logic [31:0] lcg_state = 32'he52d70be;
  int          cycle = 0;
  int          checks = 0;
  int          errors = 0;

  clk_gen clk_gen_i (.clk(clk));

  mem_2r1w_top mem_2r1w_top_i (
    .clk (clk), .rst (rst), .wr (wr), .wr_addr (wr_addr), .wr_din (wr_din),
    .rd0 (rd0), .rd1 (rd1), .rd0_addr (rd0_addr), .rd1_addr (rd1_addr),
    .rd0_vld (rd0_vld), .rd1_vld (rd1_vld), .rd0_dout (rd0_dout), .rd1_dout (rd1_dout),
    .rd0_padr (rd0_padr), .rd1_padr (rd1_padr), .ready (ready),
    .mem_write (mem_write), .mem_wr_adr (mem_wr_adr), .mem_bw (mem_bw),
    .mem_din (mem_din), .mem_read (mem_read), .mem_rd_adr (mem_rd_adr),
    .mem_rd_dout (mem_rd_dout)
  );

  for (genvar m = 0; m < NMEM; m++) begin : g_sram
    sram_model sram_i (
      .clk    (clk),
      .write  (mem_write[m]),
      .wr_adr (mem_wr_adr[m*`MEM_BITSROW +: `MEM_BITSROW]),
      .bw     (mem_bw[m*`MEM_PHYWDTH +: `MEM_PHYWDTH]),
      .din    (mem_din[m*`MEM_PHYWDTH +: `MEM_PHYWDTH]),
      .read   (mem_read[m]),
      .rd_adr (mem_rd_adr[m*`MEM_BITSROW +: `MEM_BITSROW]),
      .dout   (mem_rd_dout[m*`MEM_PHYWDTH +: `MEM_PHYWDTH])
    );
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // bank is addr mod 3, row addr div 6, slot (addr div 3) mod 2.
  function automatic padr_t expect_padr(input addr_t a, input logic fwd);
    return {fwd, bank_t'(a % 3), srow_t'(a / 6), wsel_t'((a / 3) % 2)};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // ==========================================================================
  // stimulus, one call per clock cycle.
  // ==========================================================================
  task automatic step(input logic w, input addr_t wa, input data_t wd,
                      input logic r0, input addr_t a0, input logic r1, input addr_t a1);
    logic acc;
    @(posedge clk);
    #10;
    wr       = w;
    wr_addr  = wa;
    wr_din   = wd;
    rd0      = r0;
    rd0_addr = a0;
    rd1      = r1;
    rd1_addr = a1;
    acc      = ready;
    if (acc && w) ref_mem[wa] = wd;
    if (acc && r0) exp_q0.push_back({cycle + 3, expect_padr(a0, w && a0 == wa), ref_mem[a0]});
    if (acc && r1) exp_q1.push_back({cycle + 3, expect_padr(a1, w && a1 == wa), ref_mem[a1]});
  endtask

  task automatic idle();
    step(1'b0, '0, '0, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic drain();
    int n;
    n = 0;
    idle();
    while ((exp_q0.size() > 0 || exp_q1.size() > 0) && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (exp_q0.size() > 0 || exp_q1.size() > 0) begin
      $display("read responses still outstanding at %0t", $time);
      errors++;
      exp_q0.delete();
      exp_q1.delete();
    end
  endtask

  task automatic check_response(input int port, input logic vld, input data_t dout,
                                input padr_t padr);
    logic [56:0] e;
    logic        have;
    have = (port == 0) ? (exp_q0.size() > 0) : (exp_q1.size() > 0);
    e    = '0;
    if (have) e = (port == 0) ? exp_q0[0] : exp_q1[0];
    if (vld && !have) begin
      $display("rd%0d_vld asserted at %0t with no read outstanding", port, $time);
      errors++;
    end else if (have && (vld || e[56:25] <= cycle)) begin
      if (port == 0) void'(exp_q0.pop_front());
      else void'(exp_q1.pop_front());
      if (!vld) begin
        $display("rd%0d response missing at %0t", port, $time);
        errors++;
      end else begin
        check_value($sformatf("rd%0d_vld cycle", port), e[56:25], cycle);
        check_value($sformatf("rd%0d_dout", port), e[15:0], dout);
        check_value($sformatf("rd%0d_padr", port), e[24:16], padr);
      end
    end
  endtask

  // outputs are stable at the falling edge.
  always @(negedge clk) begin
    if (!rst) begin
      check_response(0, rd0_vld, rd0_dout, rd0_padr);
      check_response(1, rd1_vld, rd1_dout, rd1_padr);
    end
  end

  task automatic report_test(input string name, input int errors_before);
    $display("test %s: %0d errors", name, errors - errors_before);
  endtask

  // ==========================================================================
  // directed tests.
  // ==========================================================================
  task automatic clear_after_reset();
    int e0;
    int n;
    e0 = errors;
    check_value("ready", 32'd0, ready);
    n = 0;
    while (!ready && n < 40) begin
      // row of address 7 is already cleared here, both strobes must be dropped.
      if (n == 20) begin
        step(1'b1, 8'd7, 16'hbeef, 1'b1, 8'd7, 1'b0, '0);
      end else begin
        idle();
      end
      n++;
    end
    if (!ready) begin
      $display("ready did not rise within 40 cycles of reset release");
      errors++;
    end
    for (int a = 0; a < `MEM_NUMADDR; a++) begin
      step(1'b0, '0, '0, 1'b1, addr_t'(a), 1'b1, addr_t'(`MEM_NUMADDR - 1 - a));
    end
    drain();
    report_test("reset_clear", e0);
  endtask

  task automatic random_write_read();
    int    e0;
    addr_t a;
    data_t d;
    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      a = addr_t'((lcg_next() >> 8) % `MEM_NUMADDR);
      d = data_t'(lcg_next() >> 16);
      step(1'b1, a, d, 1'b0, '0, 1'b0, '0);
    end
    for (int i = 0; i < `MEM_NUMADDR; i++) begin
      step(1'b0, '0, '0, 1'b1, addr_t'(i), 1'b1, addr_t'(`MEM_NUMADDR - 1 - i));
    end
    drain();
    report_test("random_rw", e0);
  endtask

  task automatic mask_isolation();
    int    e0;
    addr_t b;
    addr_t bases [5];
    e0 = errors;
    bases = '{8'd0, 8'd1, 8'd2, 8'd90, 8'd182};
    // b and b+3 share one physical row.
    for (int i = 0; i < 5; i++) begin
      b = bases[i];
      step(1'b1, b, data_t'(lcg_next() >> 16), 1'b0, '0, 1'b0, '0);
      step(1'b1, b + 8'd3, data_t'(lcg_next() >> 16), 1'b0, '0, 1'b0, '0);
      step(1'b0, '0, '0, 1'b1, b, 1'b1, b + 8'd3);
      step(1'b1, b, data_t'(lcg_next() >> 16), 1'b0, '0, 1'b0, '0);
      step(1'b0, '0, '0, 1'b1, b, 1'b1, b + 8'd3);
    end
    drain();
    report_test("mask_isolation", e0);
  endtask

  task automatic same_edge_forward();
    int    e0;
    addr_t addrs [3];
    e0 = errors;
    addrs = '{8'd50, 8'd100, 8'd191};
    for (int i = 0; i < 3; i++) begin
      step(1'b1, addrs[i], data_t'(lcg_next() >> 16), 1'b1, addrs[i], 1'b1, addrs[i]);
      step(1'b0, '0, '0, 1'b1, addrs[i], 1'b1, addrs[i]);
    end
    drain();
    report_test("forwarding", e0);
  endtask

  task automatic padr_report();
    int    e0;
    addr_t a0;
    addr_t a1;
    e0 = errors;
    for (int i = 0; i < 48; i++) begin
      a0 = addr_t'(lcg_next() % `MEM_NUMADDR);
      a1 = addr_t'((a0 + 1 + lcg_next() % (`MEM_NUMADDR - 1)) % `MEM_NUMADDR);
      step(1'b0, '0, '0, 1'b1, a0, 1'b1, a1);
    end
    drain();
    report_test("padr_report", e0);
  endtask

  // ==========================================================================
  // main sequence and watchdog.
  // ==========================================================================
  initial begin
    rst      = 1'b1;
    wr       = 1'b0;
    wr_addr  = '0;
    wr_din   = '0;
    rd0      = 1'b0;
    rd1      = 1'b0;
    rd0_addr = '0;
    rd1_addr = '0;
    for (int i = 0; i < `MEM_NUMADDR; i++) ref_mem[i] = '0;
    repeat (4) @(posedge clk);
    #10;
    rst = 1'b0;
    clear_after_reset();
    random_write_read();
    mask_isolation();
    same_edge_forward();
    padr_report();
    errors += mem_2r1w_top_i.mem_ctrl_i.mem_properties_i.fail_count;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 2 * 100);
    $display("timeout after %0d cycles, tests did not finish", TEST_CYCLES * 2);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/sram_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module sram_model (
  input  logic           clk,
  input  logic           write,
  input  mem_pkg::srow_t wr_adr,
  input  mem_pkg::phy_t  bw,
  input  mem_pkg::phy_t  din,
  input  logic           read,
  input  mem_pkg::srow_t rd_adr,
  output mem_pkg::phy_t  dout
);

  import mem_pkg::*;

  phy_t mem  [`MEM_NUMSROW];
  phy_t pipe [`MEM_SRAM_DELAY];

  // read samples the row as it was before a same-edge write.
  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_adr] <= (mem[wr_adr] & ~bw) | (din & bw);
    end
    pipe[0] <= read ? mem[rd_adr] : 'x;
    for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
      pipe[i] <= pipe[i-1];
    end
  end

  assign dout = pipe[`MEM_SRAM_DELAY-1];

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_ctrl.sv
verilog/addr_map.sv
verilog/row_align.sv
verilog/read_merge.sv
verilog/mem_2r1w_top.sv
dv/clk_gen.sv
dv/sram_model.sv
dv/mem_properties.sv
dv/mem_tb.sv

/* verilog/addr_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module addr_map (
  input  mem_pkg::addr_t addr,
  output mem_pkg::bank_t bank,
  output mem_pkg::srow_t row,
  output mem_pkg::wsel_t wsel
);

  import mem_pkg::*;

  logic [`MEM_BITADDR-1:0] quot;

  // bank row is address div 3.
  assign quot = addr / `MEM_NUMVBNK;
  assign bank = bank_t'(addr % `MEM_NUMVBNK);

  // two bank rows share one physical row.
  assign row  = srow_t'(quot / `MEM_NUMWRDS);
  assign wsel = wsel_t'(quot % `MEM_NUMWRDS);

endmodule

`default_nettype wire

/* verilog/mem_2r1w_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_2r1w_top (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              wr,
  input  mem_pkg::addr_t                                    wr_addr,
  input  mem_pkg::data_t                                    wr_din,
  input  logic                                              rd0,
  input  logic                                              rd1,
  input  mem_pkg::addr_t                                    rd0_addr,
  input  mem_pkg::addr_t                                    rd1_addr,
  output logic                                              rd0_vld,
  output logic                                              rd1_vld,
  output mem_pkg::data_t                                    rd0_dout,
  output mem_pkg::data_t                                    rd1_dout,
  output mem_pkg::padr_t                                    rd0_padr,
  output mem_pkg::padr_t                                    rd1_padr,
  output logic                                              ready,
  output logic [`MEM_NUMRDPT*`MEM_NUMVBNK-1:0]              mem_write,
  output logic [`MEM_NUMRDPT*`MEM_NUMVBNK*`MEM_BITSROW-1:0] mem_wr_adr,
  output logic [`MEM_NUMRDPT*`MEM_NUMVBNK*`MEM_PHYWDTH-1:0] mem_bw,
  output logic [`MEM_NUMRDPT*`MEM_NUMVBNK*`MEM_PHYWDTH-1:0] mem_din,
  output logic [`MEM_NUMRDPT*`MEM_NUMVBNK-1:0]              mem_read,
  output logic [`MEM_NUMRDPT*`MEM_NUMVBNK*`MEM_BITSROW-1:0] mem_rd_adr,
  input  logic [`MEM_NUMRDPT*`MEM_NUMVBNK*`MEM_PHYWDTH-1:0] mem_rd_dout
);

  import mem_pkg::*;

  logic                     init_active;
  srow_t                    init_row;
  logic                     wr_go;
  logic [`MEM_NUMRDPT-1:0]  rd_go;
  logic [`MEM_NUMRDPT-1:0]  rd_vld_pipe;
  logic [`MEM_NUMRDPT-1:0]  rd_fwrd_pipe;
  data_t                    fwd_data [`MEM_NUMRDPT];

  bank_t wr_bank;
  srow_t wr_row;
  wsel_t wr_wsel;
  bank_t rd_bank [`MEM_NUMRDPT];
  srow_t rd_row  [`MEM_NUMRDPT];
  wsel_t rd_wsel [`MEM_NUMRDPT];

  data_t [`MEM_NUMVBNK-1:0] bank_words [`MEM_NUMRDPT];

  mem_ctrl mem_ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .wr           (wr),
    .wr_addr      (wr_addr),
    .wr_din       (wr_din),
    .rd           ({rd1, rd0}),
    .rd0_addr     (rd0_addr),
    .rd1_addr     (rd1_addr),
    .ready        (ready),
    .init_active  (init_active),
    .init_row     (init_row),
    .wr_go        (wr_go),
    .rd_go        (rd_go),
    .rd_vld_pipe  (rd_vld_pipe),
    .rd_fwrd_pipe (rd_fwrd_pipe),
    .fwd_data0    (fwd_data[0]),
    .fwd_data1    (fwd_data[1])
  );

  addr_map wr_map_i  (.addr(wr_addr),  .bank(wr_bank),    .row(wr_row),    .wsel(wr_wsel));
  addr_map rd0_map_i (.addr(rd0_addr), .bank(rd_bank[0]), .row(rd_row[0]), .wsel(rd_wsel[0]));
  addr_map rd1_map_i (.addr(rd1_addr), .bank(rd_bank[1]), .row(rd_row[1]), .wsel(rd_wsel[1]));

  // ==========================================================================
  // one replica per read port, three banks each.
  // memory vectors are indexed by replica*3 + bank.
  // ==========================================================================
  for (genvar r = 0; r < `MEM_NUMRDPT; r++) begin : g_rep
    for (genvar b = 0; b < `MEM_NUMVBNK; b++) begin : g_bank
      localparam int M = r*`MEM_NUMVBNK + b;

      row_align #(.BANK_ID(b)) row_align_i (
        .clk         (clk),
        .rst         (rst),
        .init_active (init_active),
        .init_row    (init_row),
        .wr_go       (wr_go),
        .wr_bank     (wr_bank),
        .wr_row      (wr_row),
        .wr_wsel     (wr_wsel),
        .wr_din      (wr_din),
        .rd_go       (rd_go[r]),
        .rd_bank     (rd_bank[r]),
        .rd_row      (rd_row[r]),
        .rd_wsel     (rd_wsel[r]),
        .mem_write   (mem_write[M]),
        .mem_wr_adr  (mem_wr_adr[M*`MEM_BITSROW +: `MEM_BITSROW]),
        .mem_bw      (mem_bw[M*`MEM_PHYWDTH +: `MEM_PHYWDTH]),
        .mem_din     (mem_din[M*`MEM_PHYWDTH +: `MEM_PHYWDTH]),
        .mem_read    (mem_read[M]),
        .mem_rd_adr  (mem_rd_adr[M*`MEM_BITSROW +: `MEM_BITSROW]),
        .mem_rd_dout (mem_rd_dout[M*`MEM_PHYWDTH +: `MEM_PHYWDTH]),
        .rd_word     (bank_words[r][b])
      );
    end
  end

  read_merge rd0_merge_i (
    .clk        (clk),
    .rst        (rst),
    .rd_bank    (rd_bank[0]),
    .rd_row     (rd_row[0]),
    .rd_wsel    (rd_wsel[0]),
    .bank_words (bank_words[0]),
    .vld_pipe   (rd_vld_pipe[0]),
    .fwrd_pipe  (rd_fwrd_pipe[0]),
    .fwd_data   (fwd_data[0]),
    .vld        (rd0_vld),
    .dout       (rd0_dout),
    .padr       (rd0_padr)
  );

  read_merge rd1_merge_i (
    .clk        (clk),
    .rst        (rst),
    .rd_bank    (rd_bank[1]),
    .rd_row     (rd_row[1]),
    .rd_wsel    (rd_wsel[1]),
    .bank_words (bank_words[1]),
    .vld_pipe   (rd_vld_pipe[1]),
    .fwrd_pipe  (rd_fwrd_pipe[1]),
    .fwd_data   (fwd_data[1]),
    .vld        (rd1_vld),
    .dout       (rd1_dout),
    .padr       (rd1_padr)
  );

endmodule

`default_nettype wire

/* verilog/mem_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr,
  input  mem_pkg::addr_t           wr_addr,
  input  mem_pkg::data_t           wr_din,
  input  logic [`MEM_NUMRDPT-1:0]  rd,
  input  mem_pkg::addr_t           rd0_addr,
  input  mem_pkg::addr_t           rd1_addr,
  output logic                     ready,
  output logic                     init_active,
  output mem_pkg::srow_t           init_row,
  output logic                     wr_go,
  output logic [`MEM_NUMRDPT-1:0]  rd_go,
  output logic [`MEM_NUMRDPT-1:0]  rd_vld_pipe,
  output logic [`MEM_NUMRDPT-1:0]  rd_fwrd_pipe,
  output mem_pkg::data_t           fwd_data0,
  output mem_pkg::data_t           fwd_data1
);

  import mem_pkg::*;

  init_state_t state;

  addr_t                    rd_addr [`MEM_NUMRDPT];
  logic [`MEM_NUMRDPT-1:0]  fwd_now;
  logic [`MEM_NUMRDPT-1:0]  vld_q [`MEM_SRAM_DELAY];
  logic [`MEM_NUMRDPT-1:0]  fwd_q [`MEM_SRAM_DELAY];
  data_t                    dat_q [`MEM_NUMRDPT][`MEM_SRAM_DELAY];

  // ========================================================================
  // init sweep, one physical row per cycle.
  // ========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= INIT_SWEEP;
      init_row <= '0;
    end else if (state == INIT_SWEEP) begin
      init_row <= init_row + 1'b1;
      if (init_row == srow_t'(`MEM_NUMSROW - 1)) begin
        state <= INIT_DONE;
      end
    end
  end

  assign init_active = (state == INIT_SWEEP);
  assign ready       = (state == INIT_DONE);

  // strobes are dropped until ready.
  assign wr_go = wr & ready;
  assign rd_go = rd & {`MEM_NUMRDPT{ready}};

  assign rd_addr[0] = rd0_addr;
  assign rd_addr[1] = rd1_addr;

  // same-edge read and write to one address.
  always_comb begin
    for (int k = 0; k < `MEM_NUMRDPT; k++) begin
      fwd_now[k] = rd_go[k] & wr_go & (rd_addr[k] == wr_addr);
    end
  end

  // ========================================================================
  // valid and forward pipes, aligned with sram data.
  // ========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MEM_SRAM_DELAY; i++) begin
        vld_q[i] <= '0;
        fwd_q[i] <= '0;
      end
    end else begin
      vld_q[0] <= rd_go;
      fwd_q[0] <= fwd_now;
      for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
        vld_q[i] <= vld_q[i-1];
        fwd_q[i] <= fwd_q[i-1];
      end
    end
  end

  // write data only captured for a forwarding port.
  always_ff @(posedge clk) begin
    for (int k = 0; k < `MEM_NUMRDPT; k++) begin
      if (fwd_now[k]) begin
        dat_q[k][0] <= wr_din;
      end
      for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
        dat_q[k][i] <= dat_q[k][i-1];
      end
    end
  end

  assign rd_vld_pipe  = vld_q[`MEM_SRAM_DELAY-1];
  assign rd_fwrd_pipe = fwd_q[`MEM_SRAM_DELAY-1];
  assign fwd_data0    = dat_q[0][`MEM_SRAM_DELAY-1];
  assign fwd_data1    = dat_q[1][`MEM_SRAM_DELAY-1];

endmodule

`default_nettype wire

/* verilog/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// ==========================================================================
// logical geometry.
// ==========================================================================
`define MEM_WIDTH      16
`define MEM_NUMADDR    192
`define MEM_BITADDR    8

// virtual banks, address modulo 3.
`define MEM_NUMVBNK    3
`define MEM_BITVBNK    2

// ==========================================================================
// physical rows, two logical words each.
// ==========================================================================
`define MEM_NUMWRDS    2
`define MEM_BITWRDS    1
`define MEM_NUMSROW    32
`define MEM_BITSROW    5
`define MEM_PHYWDTH    32

// sram read latency in cycles.
`define MEM_SRAM_DELAY 2

`define MEM_NUMRDPT    2
`define MEM_BITPADR    9

`endif

/* verilog/mem_pkg.sv */
`default_nettype none

`include "mem_params.svh"

package mem_pkg;

  typedef logic [`MEM_BITADDR-1:0] addr_t;
  typedef logic [`MEM_WIDTH-1:0]   data_t;
  typedef logic [`MEM_BITVBNK-1:0] bank_t;
  typedef logic [`MEM_BITSROW-1:0] srow_t;
  typedef logic [`MEM_BITWRDS-1:0] wsel_t;

  // one physical row, data or bit-write mask.
  typedef logic [`MEM_PHYWDTH-1:0] phy_t;

  // {forward, bank, row, word slot}.
  typedef logic [`MEM_BITPADR-1:0] padr_t;

  // clear sweep runs once after reset.
  typedef enum logic {
    INIT_SWEEP,
    INIT_DONE
  } init_state_t;

endpackage

`default_nettype wire

/* verilog/read_merge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module read_merge (
  input  logic                                 clk,
  input  logic                                 rst,
  input  mem_pkg::bank_t                       rd_bank,
  input  mem_pkg::srow_t                       rd_row,
  input  mem_pkg::wsel_t                       rd_wsel,
  input  mem_pkg::data_t [`MEM_NUMVBNK-1:0]    bank_words,
  input  logic                                 vld_pipe,
  input  logic                                 fwrd_pipe,
  input  mem_pkg::data_t                       fwd_data,
  output logic                                 vld,
  output mem_pkg::data_t                       dout,
  output mem_pkg::padr_t                       padr
);

  import mem_pkg::*;

  bank_t bank_q [`MEM_SRAM_DELAY];
  srow_t row_q  [`MEM_SRAM_DELAY];
  wsel_t wsel_q [`MEM_SRAM_DELAY];
  data_t sel_word;

  // address fields ride along with the sram access.
  always_ff @(posedge clk) begin
    bank_q[0] <= rd_bank;
    row_q[0]  <= rd_row;
    wsel_q[0] <= rd_wsel;
    for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
      bank_q[i] <= bank_q[i-1];
      row_q[i]  <= row_q[i-1];
      wsel_q[i] <= wsel_q[i-1];
    end
  end

  // new write data wins over the stale row.
  assign sel_word = fwrd_pipe ? fwd_data : bank_words[bank_q[`MEM_SRAM_DELAY-1]];

  always_ff @(posedge clk) begin
    if (rst) begin
      vld  <= 1'b0;
      dout <= '0;
      padr <= '0;
    end else begin
      vld <= vld_pipe;
      if (vld_pipe) begin
        dout <= sel_word;
        padr <= {fwrd_pipe, bank_q[`MEM_SRAM_DELAY-1], row_q[`MEM_SRAM_DELAY-1],
                 wsel_q[`MEM_SRAM_DELAY-1]};
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/row_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module row_align #(
  parameter int BANK_ID = 0
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           init_active,
  input  mem_pkg::srow_t init_row,
  input  logic           wr_go,
  input  mem_pkg::bank_t wr_bank,
  input  mem_pkg::srow_t wr_row,
  input  mem_pkg::wsel_t wr_wsel,
  input  mem_pkg::data_t wr_din,
  input  logic           rd_go,
  input  mem_pkg::bank_t rd_bank,
  input  mem_pkg::srow_t rd_row,
  input  mem_pkg::wsel_t rd_wsel,
  output logic           mem_write,
  output mem_pkg::srow_t mem_wr_adr,
  output mem_pkg::phy_t  mem_bw,
  output mem_pkg::phy_t  mem_din,
  output logic           mem_read,
  output mem_pkg::srow_t mem_rd_adr,
  input  mem_pkg::phy_t  mem_rd_dout,
  output mem_pkg::data_t rd_word
);

  import mem_pkg::*;

  phy_t  word_mask;
  wsel_t wsel_q [`MEM_SRAM_DELAY];

  // ========================================================================
  // write side.
  // ========================================================================
  always_comb begin
    for (int w = 0; w < `MEM_NUMWRDS; w++) begin
      word_mask[w*`MEM_WIDTH +: `MEM_WIDTH] = {`MEM_WIDTH{wr_wsel == wsel_t'(w)}};
    end
  end

  // sweep overrides any write.
  assign mem_write  = init_active | (wr_go & (wr_bank == bank_t'(BANK_ID)));
  assign mem_wr_adr = init_active ? init_row : wr_row;
  assign mem_bw     = init_active ? '1 : word_mask;
  assign mem_din    = init_active ? '0 : {`MEM_NUMWRDS{wr_din}};

  // ========================================================================
  // read side.
  // ========================================================================
  assign mem_read   = rd_go & (rd_bank == bank_t'(BANK_ID));
  assign mem_rd_adr = rd_row;

  // word slot follows the sram latency.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MEM_SRAM_DELAY; i++) begin
        wsel_q[i] <= '0;
      end
    end else begin
      wsel_q[0] <= rd_wsel;
      for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
        wsel_q[i] <= wsel_q[i-1];
      end
    end
  end

  assign rd_word = mem_rd_dout[wsel_q[`MEM_SRAM_DELAY-1]*`MEM_WIDTH +: `MEM_WIDTH];

endmodule

`default_nettype wire
